/* mecobo.f */
rtl/mecobo_pkg.sv
rtl/sync_fifo.sv
rtl/ebi_host_if.sv
rtl/scheduler.sv
rtl/pin_control.sv
rtl/sample_collector.sv
rtl/mecobo.sv
testbench/tb_mecobo.sv

/* rtl/ebi_host_if.sv */
// host bus decoder: staging registers, readback, global clock, soft reset and status flags
`timescale 1ns/1ps
`default_nettype none

module ebi_host_if
  import mecobo_pkg::*;
(
  input  logic         sys_clk,
  input  logic         mecobo_reset,
  input  ebi_addr_t    ebi_addr,
  input  word_t        ebi_data_in,
  input  logic         ebi_wr_n,
  input  logic         ebi_rd_n,
  input  logic         ebi_cs_n,
  output word_t        ebi_data_out,
  output logic         ebi_data_oe,
  output logic         cmd_push,
  output cmd_t         cmd_wdata,
  input  logic         cmd_full,
  input  fifo_count_t  cmd_count,
  output logic         sample_pop,
  input  sample_word_t sample_rdata,
  input  fifo_count_t  sample_count,
  input  logic         sample_empty,
  input  logic         sample_overflow,
  output gtime_t       global_clock,
  output logic         core_reset,
  output logic         fpga_ready
);

  ebi_addr_t addr_s1;
  ebi_addr_t addr_s2;
  word_t data_s1;
  word_t data_s2;
  // {cs_n, wr_n, rd_n}
  logic [2:0] strb_s1;
  logic [2:0] strb_s2;
  logic wr_act;
  logic rd_act;
  logic wr_act_d;
  logic rd_act_d;
  logic wr_pulse;
  logic rd_pulse;
  cmd_t stage;
  logic cmd_ovf;
  logic sample_ovf;
  logic [2:0] soft_cnt;

  assign wr_act = !strb_s2[2] && !strb_s2[1];
  assign rd_act = !strb_s2[2] && !strb_s2[0];
  // first synchronized cycle of each access
  assign wr_pulse = wr_act && !wr_act_d;
  assign rd_pulse = rd_act && !rd_act_d;

  assign ebi_data_oe = rd_act;
  assign sample_pop = rd_pulse && (addr_s2 == HA_SAMPLE);
  assign fpga_ready = !sample_empty;
  assign core_reset = mecobo_reset || (soft_cnt != '0);
  assign cmd_wdata = stage;

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      strb_s1 <= '1;
      strb_s2 <= '1;
      wr_act_d <= 1'b0;
      rd_act_d <= 1'b0;
    end else begin
      strb_s1 <= {ebi_cs_n, ebi_wr_n, ebi_rd_n};
      strb_s2 <= strb_s1;
      wr_act_d <= wr_act;
      rd_act_d <= rd_act;
    end
  end

  always_ff @(posedge sys_clk) begin
    addr_s1 <= ebi_addr;
    addr_s2 <= addr_s1;
    data_s1 <= ebi_data_in;
    data_s2 <= data_s1;
  end

  // staging words for the next command
  always_ff @(posedge sys_clk) begin
    if (wr_pulse) begin
      case (addr_s2)
        HA_TIME_LO:  stage.start_time[15:0] <= data_s2;
        HA_TIME_HI:  stage.start_time[31:16] <= data_s2;
        HA_CMD_ADDR: stage.addr <= data_s2;
        HA_DATA_LO:  stage.data[15:0] <= data_s2;
        HA_DATA_HI:  stage.data[31:16] <= data_s2;
        default:     ;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      global_clock <= '0;
      cmd_push <= 1'b0;
      soft_cnt <= '0;
      cmd_ovf <= 1'b0;
      sample_ovf <= 1'b0;
    end else begin
      global_clock <= global_clock + 1'b1;
      // push follows the high data word by one cycle
      cmd_push <= wr_pulse && (addr_s2 == HA_DATA_HI);
      if (soft_cnt != '0) begin
        soft_cnt <= soft_cnt - 1'b1;
      end else if (wr_pulse && (addr_s2 == HA_SOFT_RESET) && data_s2[0]) begin
        soft_cnt <= 3'd4;
      end
      // status read clears, a new overflow in the same cycle wins
      if (rd_pulse && (addr_s2 == HA_STATUS)) begin
        cmd_ovf <= 1'b0;
        sample_ovf <= 1'b0;
      end
      if (cmd_push && cmd_full) begin
        cmd_ovf <= 1'b1;
      end
      if (sample_overflow) begin
        sample_ovf <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_pulse) begin
      case (addr_s2)
        HA_SAMPLE:       ebi_data_out <= sample_empty ? '0 : sample_rdata;
        HA_SAMPLE_COUNT: ebi_data_out <= word_t'(sample_count);
        HA_CMD_COUNT:    ebi_data_out <= word_t'(cmd_count);
        HA_CLOCK_LO:     ebi_data_out <= global_clock[15:0];
        HA_CLOCK_HI:     ebi_data_out <= global_clock[31:16];
        HA_STATUS:       ebi_data_out <= {14'h0, sample_ovf, cmd_ovf};
        default:         ebi_data_out <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/mecobo.sv */
// top level of the timed-command core; a board wrapper adds the pads and tristate buffers
`timescale 1ns/1ps
`default_nettype none

module mecobo
  import mecobo_pkg::*;
(
  input  logic      sys_clk,
  input  logic      mecobo_reset,
  input  ebi_addr_t ebi_addr,
  input  word_t     ebi_data_in,
  input  logic      ebi_wr_n,
  input  logic      ebi_rd_n,
  input  logic      ebi_cs_n,
  output word_t     ebi_data_out,
  output logic      ebi_data_oe,
  output logic      fpga_ready,
  input  pin_vec_t  pin_in,
  output pin_vec_t  pin_out,
  output pin_vec_t  pin_oe
);

  logic core_reset;
  gtime_t global_clock;

  // command path
  logic cmd_push;
  cmd_t cmd_wdata;
  cmd_t cmd_head;
  logic cmd_empty;
  logic cmd_full;
  logic cmd_pop;
  fifo_count_t cmd_count;
  cmd_bus_t cmd_bus;

  // sample path
  logic sample_strobe;
  chan_t sample_channel;
  pin_vec_t sample_level;
  logic sample_pop;
  sample_word_t sample_rdata;
  fifo_count_t sample_count;
  logic sample_empty;
  logic sample_overflow;

  ebi_host_if ebi_host_if_inst (
    .sys_clk(sys_clk),
    .mecobo_reset(mecobo_reset),
    .ebi_addr(ebi_addr),
    .ebi_data_in(ebi_data_in),
    .ebi_wr_n(ebi_wr_n),
    .ebi_rd_n(ebi_rd_n),
    .ebi_cs_n(ebi_cs_n),
    .ebi_data_out(ebi_data_out),
    .ebi_data_oe(ebi_data_oe),
    .cmd_push(cmd_push),
    .cmd_wdata(cmd_wdata),
    .cmd_full(cmd_full),
    .cmd_count(cmd_count),
    .sample_pop(sample_pop),
    .sample_rdata(sample_rdata),
    .sample_count(sample_count),
    .sample_empty(sample_empty),
    .sample_overflow(sample_overflow),
    .global_clock(global_clock),
    .core_reset(core_reset),
    .fpga_ready(fpga_ready)
  );

  sync_fifo #(
    .WIDTH($bits(cmd_t)),
    .DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) cmd_fifo_inst (
    .sys_clk(sys_clk),
    .mecobo_reset(core_reset),
    .push(cmd_push),
    .wdata(cmd_wdata),
    .pop(cmd_pop),
    .rdata(cmd_head),
    .empty(cmd_empty),
    .full(cmd_full),
    .count(cmd_count)
  );

  scheduler scheduler_inst (
    .sys_clk(sys_clk),
    .core_reset(core_reset),
    .global_clock(global_clock),
    .head(cmd_head),
    .fifo_empty(cmd_empty),
    .fifo_pop(cmd_pop),
    .cmd_bus(cmd_bus)
  );

  // one controller per pin, unit number equals pin index
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_control #(
      .PIN_INDEX(i)
    ) pin_control_inst (
      .sys_clk(sys_clk),
      .core_reset(core_reset),
      .cmd_bus(cmd_bus),
      .pin_in(pin_in[i]),
      .pin_out(pin_out[i]),
      .pin_oe(pin_oe[i]),
      .sample_strobe(sample_strobe),
      .sample_channel(sample_channel),
      .sample_level(sample_level[i])
    );
  end

  sample_collector sample_collector_inst (
    .sys_clk(sys_clk),
    .core_reset(core_reset),
    .cmd_bus(cmd_bus),
    .global_clock(global_clock),
    .sample_strobe(sample_strobe),
    .sample_channel(sample_channel),
    .sample_level(sample_level),
    .sample_pop(sample_pop),
    .sample_rdata(sample_rdata),
    .sample_count(sample_count),
    .sample_empty(sample_empty),
    .sample_overflow(sample_overflow)
  );

endmodule

`default_nettype wire

/* rtl/mecobo_pkg.sv */
// shared widths, command and bus structs, address map and pin modes; import into every block
`default_nettype none

package mecobo_pkg;

  localparam int NUM_PINS = 8;
  localparam int FIFO_DEPTH_LOG2 = 5;

  typedef logic [15:0] word_t;
  typedef logic [18:0] ebi_addr_t;
  typedef logic [31:0] gtime_t;
  typedef logic [15:0] cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [7:0] cmd_byte_t;
  typedef logic [NUM_PINS-1:0] pin_vec_t;
  typedef logic [$clog2(NUM_PINS)-1:0] chan_t;
  typedef logic [FIFO_DEPTH_LOG2:0] fifo_count_t;

  // channel[15:12], clock[10:0] in [11:1], level in [0]
  typedef word_t sample_word_t;

  typedef struct packed {
    gtime_t    start_time;
    cmd_addr_t addr;
    cmd_data_t data;
  } cmd_t;

  typedef struct packed {
    logic      en;
    cmd_addr_t addr;
    cmd_data_t data;
  } cmd_bus_t;

  typedef enum logic [1:0] {
    PIN_OFF,
    PIN_CONST,
    PIN_SQUARE,
    PIN_SAMPLE
  } pin_mode_t;

  // command bus units and registers
  localparam cmd_byte_t UNIT_COLLECTOR = 8'hF0;
  localparam cmd_byte_t REG_PIN_MODE = 8'd0;
  localparam cmd_byte_t REG_PIN_HALF_PERIOD = 8'd1;
  localparam cmd_byte_t REG_PIN_LEVEL = 8'd2;
  localparam cmd_byte_t REG_COL_MASK = 8'd0;
  localparam cmd_byte_t REG_COL_PERIOD = 8'd1;

  // host word addresses
  localparam ebi_addr_t HA_TIME_LO = 19'd0;
  localparam ebi_addr_t HA_TIME_HI = 19'd1;
  localparam ebi_addr_t HA_CMD_ADDR = 19'd2;
  localparam ebi_addr_t HA_DATA_LO = 19'd3;
  localparam ebi_addr_t HA_DATA_HI = 19'd4;
  localparam ebi_addr_t HA_SAMPLE = 19'd5;
  localparam ebi_addr_t HA_SAMPLE_COUNT = 19'd6;
  localparam ebi_addr_t HA_CMD_COUNT = 19'd7;
  localparam ebi_addr_t HA_CLOCK_LO = 19'd8;
  localparam ebi_addr_t HA_CLOCK_HI = 19'd9;
  localparam ebi_addr_t HA_SOFT_RESET = 19'd10;
  localparam ebi_addr_t HA_STATUS = 19'd11;

endpackage

`default_nettype wire

/* rtl/pin_control.sv */
// one pin: mode registers from the command bus, square wave and synchronized input sampling
`timescale 1ns/1ps
`default_nettype none

module pin_control
  import mecobo_pkg::*;
#(
  parameter int PIN_INDEX = 0
) (
  input  logic     sys_clk,
  input  logic     core_reset,
  input  cmd_bus_t cmd_bus,
  input  logic     pin_in,
  output logic     pin_out,
  output logic     pin_oe,
  input  logic     sample_strobe,
  input  chan_t    sample_channel,
  output logic     sample_level
);

  pin_mode_t mode;
  cmd_data_t half_period;
  cmd_data_t sq_limit;
  cmd_data_t sq_cnt;
  logic level;
  logic sq_level;
  logic hit;
  logic mode_wr;
  logic in_meta;
  logic in_sync;

  assign hit = cmd_bus.en && (cmd_bus.addr[15:8] == 8'(PIN_INDEX));
  assign mode_wr = hit && (cmd_bus.addr[7:0] == REG_PIN_MODE);
  // zero half-period runs like one
  assign sq_limit = (half_period == '0) ? '0 : half_period - 1'b1;

  always_ff @(posedge sys_clk) begin
    if (core_reset) begin
      mode <= PIN_OFF;
      half_period <= '0;
      level <= 1'b0;
    end else if (hit) begin
      case (cmd_bus.addr[7:0])
        REG_PIN_MODE:        mode <= pin_mode_t'(cmd_bus.data[1:0]);
        REG_PIN_HALF_PERIOD: half_period <= cmd_bus.data;
        REG_PIN_LEVEL:       level <= cmd_bus.data[0];
        default:             ;
      endcase
    end
  end

  // half-period counter, restarted on any mode write
  always_ff @(posedge sys_clk) begin
    if (core_reset) begin
      sq_cnt <= '0;
      sq_level <= 1'b0;
    end else if (mode_wr) begin
      sq_cnt <= '0;
      sq_level <= 1'b0;
    end else if (mode == PIN_SQUARE) begin
      if (sq_cnt >= sq_limit) begin
        sq_cnt <= '0;
        sq_level <= !sq_level;
      end else begin
        sq_cnt <= sq_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (mode)
      PIN_CONST:  pin_out = level;
      PIN_SQUARE: pin_out = sq_level;
      default:    pin_out = 1'b0;
    endcase
  end

  assign pin_oe = (mode == PIN_CONST) || (mode == PIN_SQUARE);

  // two-flop synchronizer on the pad input
  always_ff @(posedge sys_clk) begin
    in_meta <= pin_in;
    in_sync <= in_meta;
  end

  assign sample_level = sample_strobe && (sample_channel == chan_t'(PIN_INDEX)) &&
                        (mode == PIN_SAMPLE) && in_sync;

endmodule

`default_nettype wire

/* rtl/sample_collector.sv */
// periodic sweep over the enabled channels, packing sample words into the sample FIFO
`timescale 1ns/1ps
`default_nettype none

module sample_collector
  import mecobo_pkg::*;
(
  input  logic         sys_clk,
  input  logic         core_reset,
  input  cmd_bus_t     cmd_bus,
  input  gtime_t       global_clock,
  output logic         sample_strobe,
  output chan_t        sample_channel,
  input  pin_vec_t     sample_level,
  input  logic         sample_pop,
  output sample_word_t sample_rdata,
  output fifo_count_t  sample_count,
  output logic         sample_empty,
  output logic         sample_overflow
);

  typedef enum logic [1:0] {
    IDLE,
    SELECT,
    CAPTURE
  } sweep_state_t;

  sweep_state_t state;
  pin_vec_t mask;
  pin_vec_t pending;
  pin_vec_t pending_next;
  cmd_data_t period;
  cmd_data_t period_last;
  cmd_data_t period_cnt;
  chan_t chan;
  logic hit;
  logic tick;
  logic level_q;
  logic push;
  logic full;
  sample_word_t wdata;

  function automatic chan_t lowest_bit(input pin_vec_t v);
    chan_t idx;
    idx = '0;
    for (int i = NUM_PINS - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = chan_t'(i);
      end
    end
    return idx;
  endfunction

  assign hit = cmd_bus.en && (cmd_bus.addr[15:8] == UNIT_COLLECTOR);
  assign period_last = (period == '0) ? '0 : period - 1'b1;
  assign tick = (period_cnt >= period_last);
  assign pending_next = pending & ~(pin_vec_t'(1) << chan);

  assign sample_strobe = (state == SELECT);
  assign sample_channel = chan;
  assign push = (state == CAPTURE);
  assign wdata = {4'(chan), global_clock[10:0], level_q};
  assign sample_overflow = push && full;

  always_ff @(posedge sys_clk) begin
    if (core_reset) begin
      mask <= '0;
      period <= '0;
      period_cnt <= '0;
      state <= IDLE;
      pending <= '0;
      chan <= '0;
      level_q <= 1'b0;
    end else begin
      if (hit && (cmd_bus.addr[7:0] == REG_COL_MASK)) begin
        mask <= cmd_bus.data[NUM_PINS-1:0];
      end
      if (hit && (cmd_bus.addr[7:0] == REG_COL_PERIOD)) begin
        period <= cmd_bus.data;
        period_cnt <= '0;
      end else if (tick) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          // a tick during a sweep is skipped
          if (tick && (mask != '0)) begin
            pending <= mask;
            chan <= lowest_bit(mask);
            state <= SELECT;
          end
        end
        SELECT: begin
          level_q <= sample_level[chan];
          state <= CAPTURE;
        end
        default: begin
          pending <= pending_next;
          chan <= lowest_bit(pending_next);
          state <= (pending_next != '0) ? SELECT : IDLE;
        end
      endcase
    end
  end

  sync_fifo #(
    .WIDTH($bits(sample_word_t)),
    .DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) sample_fifo_inst (
    .sys_clk(sys_clk),
    .mecobo_reset(core_reset),
    .push(push),
    .wdata(wdata),
    .pop(sample_pop),
    .rdata(sample_rdata),
    .empty(sample_empty),
    .full(full),
    .count(sample_count)
  );

endmodule

`default_nettype wire

/* rtl/scheduler.sv */
// releases queued commands onto the command bus once the global clock reaches their start time
`timescale 1ns/1ps
`default_nettype none

module scheduler
  import mecobo_pkg::*;
(
  input  logic     sys_clk,
  input  logic     core_reset,
  input  gtime_t   global_clock,
  input  cmd_t     head,
  input  logic     fifo_empty,
  output logic     fifo_pop,
  output cmd_bus_t cmd_bus
);

  typedef enum logic {
    IDLE,
    WAIT_TIME
  } sched_state_t;

  sched_state_t state;
  cmd_t cur;
  logic due;
  logic load;
  logic bus_en;
  cmd_addr_t bus_addr;
  cmd_data_t bus_data;

  // late commands are due at once
  assign due = (state == WAIT_TIME) && (cur.start_time <= global_clock);
  // take the next head while idle or in the same cycle as an issue
  assign load = ((state == IDLE) || due) && !fifo_empty;
  assign fifo_pop = load;

  assign cmd_bus = '{en: bus_en, addr: bus_addr, data: bus_data};

  always_ff @(posedge sys_clk) begin
    if (core_reset) begin
      state <= IDLE;
      bus_en <= 1'b0;
    end else begin
      bus_en <= due;
      if (load) begin
        state <= WAIT_TIME;
      end else if (due) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (load) begin
      cur <= head;
    end
    if (due) begin
      bus_addr <= cur.addr;
      bus_data <= cur.data;
    end
  end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
// first-word-fall-through FIFO with occupancy count, used for command and sample queues
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH_LOG2 = 5
) (
  input  logic                sys_clk,
  input  logic                mecobo_reset,
  input  logic                push,
  input  logic [WIDTH-1:0]    wdata,
  input  logic                pop,
  output logic [WIDTH-1:0]    rdata,
  output logic                empty,
  output logic                full,
  output logic [DEPTH_LOG2:0] count
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  // push on full and pop on empty are dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  assign empty = (count == '0);
  assign full = count[DEPTH_LOG2];
  // head word shows while not empty
  assign rdata = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_mecobo.sv */
// testbench for the mecobo core; drives the host bus and pins, checks against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_mecobo
  import mecobo_pkg::*;
();

  localparam int CLK_HALF = 20;
  // reset, about 30 commands of 55 cycles, a 3000-cycle hold, square wave and up to 17
  // sample reads at a 200-cycle period come to about 10k cycles, doubled for margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic      sys_clk;
  logic      mecobo_reset;
  ebi_addr_t ebi_addr;
  word_t     ebi_data_in;
  logic      ebi_wr_n;
  logic      ebi_rd_n;
  logic      ebi_cs_n;
  word_t     ebi_data_out;
  logic      ebi_data_oe;
  logic      fpga_ready;
  pin_vec_t  pin_in;
  pin_vec_t  pin_out;
  pin_vec_t  pin_oe;

  int errors;
  int checks;
  int cycles;

  mecobo mecobo_inst (
    .sys_clk(sys_clk),
    .mecobo_reset(mecobo_reset),
    .ebi_addr(ebi_addr),
    .ebi_data_in(ebi_data_in),
    .ebi_wr_n(ebi_wr_n),
    .ebi_rd_n(ebi_rd_n),
    .ebi_cs_n(ebi_cs_n),
    .ebi_data_out(ebi_data_out),
    .ebi_data_oe(ebi_data_oe),
    .fpga_ready(fpga_ready),
    .pin_in(pin_in),
    .pin_out(pin_out),
    .pin_oe(pin_oe)
  );

  initial sys_clk = 1'b0;
  always #CLK_HALF sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped at the cycle limit of %0d before the tests finished", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #5;
  endtask

  task automatic host_write(input ebi_addr_t addr, input word_t data);
    next_cycle();
    ebi_addr = addr;
    ebi_data_in = data;
    ebi_cs_n = 1'b0;
    ebi_wr_n = 1'b0;
    repeat (6) next_cycle();
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    // idle gap so the synchronized strobes see the end of the access
    repeat (4) next_cycle();
  endtask

  task automatic host_read(input ebi_addr_t addr, output word_t data);
    next_cycle();
    ebi_addr = addr;
    ebi_cs_n = 1'b0;
    ebi_rd_n = 1'b0;
    // data is valid three cycles after the strobes fall
    repeat (6) next_cycle();
    data = ebi_data_out;
    check_value("read data enable", 1, ebi_data_oe);
    ebi_cs_n = 1'b1;
    ebi_rd_n = 1'b1;
    repeat (4) next_cycle();
    check_value("data enable after read", 0, ebi_data_oe);
  endtask

  task automatic send_cmd(input gtime_t start, input cmd_byte_t unit, input cmd_byte_t reg_sel,
                          input cmd_data_t data);
    host_write(HA_TIME_LO, start[15:0]);
    host_write(HA_TIME_HI, start[31:16]);
    host_write(HA_CMD_ADDR, {unit, reg_sel});
    host_write(HA_DATA_LO, data[15:0]);
    host_write(HA_DATA_HI, data[31:16]);
  endtask

  task automatic wait_cmd_drain();
    word_t n;
    n = 16'hFFFF;
    while (n != 16'h0) begin
      host_read(HA_CMD_COUNT, n);
    end
  endtask

  task automatic wait_ready(input int limit, output logic ok);
    int n;
    n = 0;
    while (!fpga_ready && (n < limit)) begin
      next_cycle();
      n++;
    end
    ok = fpga_ready;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // n-th sample word of a run: channel walks the set mask bits upward and wraps,
  // level is the pin input only where the pin is in sample mode, clock field left 0
  function automatic word_t expected_sample(input int n, input pin_vec_t mask,
                                            input pin_vec_t sample_pins, input pin_vec_t pins);
    int count;
    int k;
    int ch;
    count = 0;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (mask[i]) begin
        count++;
      end
    end
    k = n % count;
    ch = -1;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (mask[i] && (ch < 0)) begin
        if (k == 0) begin
          ch = i;
        end else begin
          k--;
        end
      end
    end
    return {4'(ch), 11'h0, sample_pins[ch] & pins[ch]};
  endfunction

  initial begin
    word_t rd;
    gtime_t now;
    gtime_t target;
    pin_vec_t exp_out;
    pin_vec_t sample_pins;
    pin_vec_t col_mask;
    int half;
    int n;
    logic prev;
    logic ok;

    void'($urandom(32'h274d5101));
    errors = 0;
    checks = 0;
    mecobo_reset = 1'b1;
    ebi_addr = '0;
    ebi_data_in = '0;
    ebi_wr_n = 1'b1;
    ebi_rd_n = 1'b1;
    ebi_cs_n = 1'b1;
    pin_in = '0;
    repeat (16) @(posedge sys_clk);
    #5;
    mecobo_reset = 1'b0;
    next_cycle();

    check_value("reset pin_oe", 0, pin_oe);
    check_value("reset pin_out", 0, pin_out);
    check_value("reset fpga_ready", 0, fpga_ready);
    check_value("reset data enable", 0, ebi_data_oe);
    host_read(HA_CMD_COUNT, rd);
    check_value("reset cmd count", 0, rd);
    host_read(HA_SAMPLE_COUNT, rd);
    check_value("reset sample count", 0, rd);

    // constant levels on every pin, due at once
    exp_out = pin_vec_t'($urandom);
    for (int i = 0; i < NUM_PINS; i++) begin
      send_cmd(0, cmd_byte_t'(i), REG_PIN_LEVEL, exp_out[i]);
      send_cmd(0, cmd_byte_t'(i), REG_PIN_MODE, PIN_CONST);
    end
    wait_cmd_drain();
    check_value("const pin_oe", 8'hFF, pin_oe);
    check_value("const pin_out", exp_out, pin_out);

    // pin 0 flips 3000 cycles from now, the run stays below 2^16 cycles
    host_read(HA_CLOCK_LO, rd);
    now[15:0] = rd;
    host_read(HA_CLOCK_HI, rd);
    now[31:16] = rd;
    target = now + 3000;
    send_cmd(target, 8'd0, REG_PIN_LEVEL, !exp_out[0]);
    do begin
      host_read(HA_CLOCK_LO, rd);
      // pins are looked at a few cycles after the clock read
      if (gtime_t'(rd) + 16 < target) begin
        check_value("held pin_out", exp_out, pin_out);
      end
    end while (gtime_t'(rd) < target);
    exp_out[0] = !exp_out[0];
    check_value("released pin_out", exp_out, pin_out);

    // square wave on pin 1
    half = 3 + ($urandom % 18);
    send_cmd(0, 8'd1, REG_PIN_HALF_PERIOD, half);
    send_cmd(0, 8'd1, REG_PIN_MODE, PIN_SQUARE);
    wait_cmd_drain();
    for (int e = 0; e < 4; e++) begin
      prev = pin_out[1];
      n = 0;
      while ((pin_out[1] == prev) && (n < 100)) begin
        next_cycle();
        n++;
      end
      // first interval starts somewhere inside a half-period
      if (e > 0) begin
        check_value("square half-period", half, n);
      end
    end

    // sampling sweep
    sample_pins = pin_vec_t'($urandom);
    // pin 0 stays constant so soft reset has a driver to release
    sample_pins[0] = 1'b0;
    col_mask = pin_vec_t'($urandom);
    if (col_mask == '0) begin
      col_mask = 8'h01;
    end
    pin_in = pin_vec_t'($urandom);
    for (int i = 0; i < NUM_PINS; i++) begin
      if (sample_pins[i]) begin
        send_cmd(0, cmd_byte_t'(i), REG_PIN_MODE, PIN_SAMPLE);
      end
    end
    send_cmd(0, UNIT_COLLECTOR, REG_COL_PERIOD, 200);
    send_cmd(0, UNIT_COLLECTOR, REG_COL_MASK, col_mask);
    for (int w = 0; w < 2 * NUM_PINS + 1; w++) begin
      wait_ready(400, ok);
      if (!ok) begin
        errors++;
        $display("fpga_ready stayed low while waiting for sample word %0d", w);
      end
      host_read(HA_SAMPLE, rd);
      check_value("sample channel and level",
                  expected_sample(w, col_mask, sample_pins, pin_in), rd & 16'hF001);
    end
    host_read(HA_STATUS, rd);
    check_value("no overflow", 0, rd);

    // two far-future commands, one held by the scheduler and one left queued
    send_cmd(32'hFFFF_FFFF, 8'd0, REG_PIN_LEVEL, 1);
    send_cmd(32'hFFFF_FFFF, 8'd0, REG_PIN_LEVEL, 1);
    host_read(HA_CMD_COUNT, rd);
    check_value("queued cmd count", 1, rd);
    check_value("driven pins before soft reset", pin_vec_t'(~sample_pins), pin_oe);

    // soft reset with samples still queued
    wait_ready(400, ok);
    check_value("ready before soft reset", 1, ok);
    host_write(HA_SOFT_RESET, 16'h0001);
    check_value("soft reset pin_oe", 0, pin_oe);
    check_value("soft reset fpga_ready", 0, fpga_ready);
    host_read(HA_CMD_COUNT, rd);
    check_value("soft reset cmd count", 0, rd);
    host_read(HA_SAMPLE_COUNT, rd);
    check_value("soft reset sample count", 0, rd);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
